//--- fp_multiplier_tests.txt
# name op_a op_b expected_result expected_flags, all values in hex
# flags bits are invalid overflow underflow inexact, from msb to lsb
mul_1p5_2         3FC00000 40000000 40400000 0
mul_3_neg0p5      40400000 BF000000 BFC00000 0
mul_1_1           3F800000 3F800000 3F800000 0
mul_neg2_neg4     C0000000 C0800000 41000000 0
mul_1p5_1p5       3FC00000 3FC00000 40100000 0
round_third_3     3EAAAAAB 40400000 3F800000 1
round_tie_up      3F800001 3FC00000 3FC00002 1
round_tie_even    3F800002 3FA00000 3FA00002 1
round_shift_down  3FFFFFFF 3F800001 40000000 1
round_carry_out   3FFFFFFE 3F800001 40000000 1
nan_a             7FC00000 3F800000 7FC00000 8
nan_b_signaling   3F800000 FF800001 7FC00000 8
nan_times_inf     7F800000 7FC00000 7FC00000 8
inf_times_zero    7F800000 00000000 FFC00000 8
zero_times_inf    80000000 FF800000 FFC00000 8
inf_times_neg2    7F800000 C0000000 FF800000 0
zero_times_3      00000000 40400000 00000000 0
negzero_times_3   80000000 40400000 80000000 0
denorm_times_neg1 00000001 BF800000 80000000 0
overflow_pos      7F000000 40000000 7F800000 5
overflow_neg      FF7FFFFF 7F7FFFFF FF800000 5
overflow_round    7F7FFFFF 3F800001 7F800000 5
underflow_pos     00800000 3F000000 00000000 3
underflow_neg     80800000 00800000 80000000 3
min_normal_exact  00800000 3F800000 00800000 0
max_finite_exact  7F7FFFFF 3F800000 7F7FFFFF 0

//--- list.f
+incdir+.
fpm_pkg.sv
fpm_classify.sv
fpm_mant_mul.sv
fpm_normalize.sv
fpm_round_pack.sv
fp_multiplier.sv
fp_multiplier_asserts.sv
tb_fp_multiplier.sv

//--- tb_fp_multiplier.sv
`timescale 1ns/1ns

module tb_fp_multiplier;

  localparam int wait_limit = 200;

  logic                clk;
  logic                rst_n;
  logic                in_valid;
  logic                in_ready;
  fpm_pkg::fp32_t      op_a;
  fpm_pkg::fp32_t      op_b;
  logic                out_valid;
  logic                out_ready;
  fpm_pkg::fp32_t      result;
  fpm_pkg::fpm_flags_t flags;

  string               names[$];
  fpm_pkg::fp32_t      vec_a[$];
  fpm_pkg::fp32_t      vec_b[$];
  fpm_pkg::fp32_t      vec_result[$];
  fpm_pkg::fpm_flags_t vec_flags[$];
  int                  expect_q[$];
  integer              seed;
  logic                random_ready;
  int                  latency;

  fp_multiplier UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .op_a      (op_a),
    .op_b      (op_b),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .result    (result),
    .flags     (flags)
  );

  always #20 clk = ~clk;

  // sink is stalled about one cycle in four once random mode is on
  always @(posedge clk) begin
    #2;
    if (random_ready) begin
      out_ready = ($random(seed) & 3) != 0;
    end else begin
      out_ready = 1'b1;
    end
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1);
  endtask

  // a failed bound assertion ends the run at the next falling edge
  always @(negedge clk) begin
    if (UUT.u_asserts.failures != 0) begin
      abort_run("bound assertion failed");
    end
  end

  task automatic check_result(input string name, input fpm_pkg::fp32_t expected,
                              input fpm_pkg::fp32_t actual);
    if (actual !== expected) begin
      $display("mismatch %s result: expected %h, actual %h", name, expected, actual);
      abort_run("result check failed");
    end
  endtask

  task automatic check_flags(input string name, input fpm_pkg::fpm_flags_t expected,
                             input fpm_pkg::fpm_flags_t actual);
    if (actual !== expected) begin
      $display("mismatch %s flags: expected %h, actual %h", name, expected, actual);
      abort_run("flags check failed");
    end
  endtask

  task automatic verify_latency(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("mismatch %s latency: expected %0d, actual %0d", name, expected, actual);
      abort_run("latency check failed");
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    string       name;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [3:0]  f;
    fd = $fopen("fp_multiplier_tests.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open fp_multiplier_tests.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() > 1 && line.substr(0, 0) != "#") begin
        n = $sscanf(line, "%s %h %h %h %h", name, a, b, r, f);
        if (n == 5) begin
          names.push_back(name);
          vec_a.push_back(a);
          vec_b.push_back(b);
          vec_result.push_back(r);
          vec_flags.push_back(f);
        end
      end
    end
    $fclose(fd);
    if (names.size() < 2) begin
      abort_run("too few test vectors in fp_multiplier_tests.txt");
    end
  endtask

  // called 2 ns after a rising edge, returns 2 ns after the accepting edge
  task automatic send_operands(input int idx);
    int waited;
    waited   = 0;
    op_a     = vec_a[idx];
    op_b     = vec_b[idx];
    in_valid = 1'b1;
    @(negedge clk);
    while (!in_ready) begin
      waited++;
      if (waited > wait_limit) begin
        abort_run("timeout waiting for in_ready");
      end
      @(negedge clk);
    end
    expect_q.push_back(idx);
    @(posedge clk);
    #2;
  endtask

  // cycles counts the falling edges seen up to the one before the output transfer
  task automatic receive_result(output int cycles);
    int idx;
    cycles = 1;
    @(negedge clk);
    while (!(out_valid && out_ready)) begin
      cycles++;
      if (cycles > wait_limit) begin
        abort_run("timeout waiting for result");
      end
      @(negedge clk);
    end
    if (expect_q.size() == 0) begin
      abort_run("result delivered with no operation pending");
    end
    idx = expect_q.pop_front();
    check_result(names[idx], vec_result[idx], result);
    check_flags(names[idx], vec_flags[idx], flags);
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    op_a         = '0;
    op_b         = '0;
    out_ready    = 1'b1;
    random_ready = 1'b0;
    seed         = 32'h7bb0;
    load_vectors();

    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    if (out_valid !== 1'b0) begin
      abort_run("out_valid is high right after reset");
    end
    check_result("reset", '0, result);
    check_flags("reset", '0, flags);

    // first operation alone with the sink always ready
    @(posedge clk);
    #2;
    send_operands(0);
    in_valid = 1'b0;
    receive_result(latency);
    verify_latency(names[0], 4, latency);
    random_ready = 1'b1;
    @(posedge clk);
    #2;

    fork
      begin
        for (int i = 1; i < names.size(); i++) begin
          send_operands(i);
        end
        in_valid = 1'b0;
      end
      begin
        for (int i = 1; i < names.size(); i++) begin
          receive_result(latency);
        end
      end
    join

    random_ready = 1'b0;
    repeat (6) begin
      @(negedge clk);
      if (out_valid) begin
        abort_run("extra result after all operations completed");
      end
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

//--- fp_multiplier_asserts.sv
`timescale 1ns/1ns

module fp_multiplier_asserts (
  input logic                clk,
  input logic                rst_n,
  input logic                out_valid,
  input logic                out_ready,
  input fpm_pkg::fp32_t      result,
  input fpm_pkg::fpm_flags_t flags
);

  // failed assertions so far, watched by the testbench
  int failures = 0;

  // output register is cleared while reset is held
  property reset_clears_output;
    @(posedge clk) !rst_n |-> (!out_valid && result == '0 && flags == '0);
  endproperty

  property output_stable_when_stalled;
    @(posedge clk) disable iff (!rst_n)
      (out_valid && !out_ready) |=> ($stable(result) && $stable(flags));
  endproperty

  // a result is never withdrawn before it is taken
  property valid_held_until_taken;
    @(posedge clk) disable iff (!rst_n)
      (out_valid && !out_ready) |=> out_valid;
  endproperty

  a_reset_clears_output: assert property (reset_clears_output)
    else begin
      failures++;
      $error("output not cleared during reset");
    end
  a_output_stable: assert property (output_stable_when_stalled)
    else begin
      failures++;
      $error("result or flags changed while stalled");
    end
  a_valid_held: assert property (valid_held_until_taken)
    else begin
      failures++;
      $error("out_valid dropped before out_ready");
    end

endmodule

bind fp_multiplier fp_multiplier_asserts u_asserts (
  .clk       (clk),
  .rst_n     (rst_n),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .result    (result),
  .flags     (flags)
);

//--- fp_multiplier.sv
`timescale 1ns/1ns

module fp_multiplier (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  output logic                in_ready,
  input  fpm_pkg::fp32_t      op_a,
  input  fpm_pkg::fp32_t      op_b,
  output logic                out_valid,
  input  logic                out_ready,
  output fpm_pkg::fp32_t      result,
  output fpm_pkg::fpm_flags_t flags
);

  // stage links, named by the stage that drives valid
  logic                  s1_valid;
  logic                  s2_ready;
  fpm_pkg::fpm_ops_t     s1_ops;
  fpm_pkg::fpm_special_t s1_special;

  logic                  s2_valid;
  logic                  s3_ready;
  fpm_pkg::fpm_prod_t    s2_prod;
  fpm_pkg::fpm_special_t s2_special;

  logic                  s3_valid;
  logic                  s4_ready;
  fpm_pkg::fpm_prod_t    s3_prod;
  fpm_pkg::fpm_special_t s3_special;

  fpm_classify u_classify (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .op_a      (op_a),
    .op_b      (op_b),
    .out_valid (s1_valid),
    .out_ready (s2_ready),
    .ops       (s1_ops),
    .special   (s1_special)
  );

  fpm_mant_mul u_mant_mul (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (s1_valid),
    .in_ready    (s2_ready),
    .ops         (s1_ops),
    .special_in  (s1_special),
    .out_valid   (s2_valid),
    .out_ready   (s3_ready),
    .prod        (s2_prod),
    .special_out (s2_special)
  );

  fpm_normalize u_normalize (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (s2_valid),
    .in_ready    (s3_ready),
    .prod_in     (s2_prod),
    .special_in  (s2_special),
    .out_valid   (s3_valid),
    .out_ready   (s4_ready),
    .prod_out    (s3_prod),
    .special_out (s3_special)
  );

  fpm_round_pack u_round_pack (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (s3_valid),
    .in_ready  (s4_ready),
    .prod      (s3_prod),
    .special   (s3_special),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .result    (result),
    .flags     (flags)
  );

endmodule

//--- fpm_round_pack.sv
`timescale 1ns/1ns
`include "fpm_macros.svh"

module fpm_round_pack (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  fpm_pkg::fpm_prod_t    prod,
  input  fpm_pkg::fpm_special_t special,
  output logic                  out_valid,
  input  logic                  out_ready,
  output fpm_pkg::fp32_t        result,
  output fpm_pkg::fpm_flags_t   flags
);

  logic                         lsb;
  logic                         guard;
  logic                         rnd;
  logic                         sticky;
  logic                         round_up;
  logic [`FPM_MANT_W+1:0]       sig_rnd;
  logic                         carry;
  logic signed [`FPM_EXP_W+1:0] exp_post;
  logic [`FPM_MANT_W-1:0]       frac_post;
  logic                         overflow;
  logic                         underflow;
  fpm_pkg::fp32_t               result_next;
  fpm_pkg::fpm_flags_t          flags_next;

  // leading one sits at bit 46, kept bits are 46..23
  assign lsb      = prod.sig[`FPM_MANT_W];
  assign guard    = prod.sig[`FPM_MANT_W-1];
  assign rnd      = prod.sig[`FPM_MANT_W-2];
  assign sticky   = |prod.sig[`FPM_MANT_W-3:0];
  assign round_up = guard && (rnd || sticky || lsb);

  assign sig_rnd  = {1'b0, prod.sig[`FPM_PROD_W-2:`FPM_MANT_W]} + {{(`FPM_MANT_W+1){1'b0}}, round_up};
  assign carry    = sig_rnd[`FPM_MANT_W+1];

  // on carry out the significand is 1.000... and its fraction bits are already zero
  assign frac_post = sig_rnd[`FPM_MANT_W-1:0];
  assign exp_post  = carry ? prod.exp + 10'sd1 : prod.exp;

  assign overflow  = exp_post >= $signed({2'b00, `FPM_EXP_MAX});
  assign underflow = exp_post <= 10'sd0;

  always_comb begin
    result_next      = '0;
    flags_next       = '0;
    result_next.sign = prod.sign;
    flags_next.inexact = guard || rnd || sticky;
    if (special.override) begin
      result_next = special.result;
      flags_next  = special.flags;
    end else if (overflow) begin
      result_next.exp      = `FPM_EXP_MAX;
      flags_next.overflow  = 1'b1;
      flags_next.inexact   = 1'b1;
    end else if (underflow) begin
      // flush to signed zero
      flags_next.underflow = 1'b1;
      flags_next.inexact   = 1'b1;
    end else begin
      result_next.exp  = exp_post[`FPM_EXP_W-1:0];
      result_next.frac = frac_post;
    end
  end

  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      result    <= '0;
      flags     <= '0;
    end else begin
      if (in_ready) begin
        out_valid <= in_valid;
      end
      if (in_valid && in_ready) begin
        result <= result_next;
        flags  <= flags_next;
      end
    end
  end

endmodule

//--- fpm_normalize.sv
`timescale 1ns/1ns
`include "fpm_macros.svh"

module fpm_normalize (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  fpm_pkg::fpm_prod_t    prod_in,
  input  fpm_pkg::fpm_special_t special_in,
  output logic                  out_valid,
  input  logic                  out_ready,
  output fpm_pkg::fpm_prod_t    prod_out,
  output fpm_pkg::fpm_special_t special_out
);

  fpm_pkg::fpm_prod_t prod_next;
  logic               top_bit;

  // product of two values in [1,2) lies in [1,4), so one shift at most
  assign top_bit = prod_in.sig[`FPM_PROD_W-1];

  always_comb begin
    prod_next = prod_in;
    if (top_bit) begin
      prod_next.exp = prod_in.exp + 10'sd1;
      // bit shifted out is folded into bit 0 so sticky still sees it
      prod_next.sig = {1'b0, prod_in.sig[`FPM_PROD_W-1:2], prod_in.sig[1] | prod_in.sig[0]};
    end
  end

  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      prod_out    <= prod_next;
      special_out <= special_in;
    end
  end

endmodule

//--- fpm_mant_mul.sv
`timescale 1ns/1ns
`include "fpm_macros.svh"

module fpm_mant_mul (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  fpm_pkg::fpm_ops_t     ops,
  input  fpm_pkg::fpm_special_t special_in,
  output logic                  out_valid,
  input  logic                  out_ready,
  output fpm_pkg::fpm_prod_t    prod,
  output fpm_pkg::fpm_special_t special_out
);

  fpm_pkg::fpm_prod_t prod_next;

  always_comb begin
    prod_next.sign = ops.sign_a ^ ops.sign_b;
    // widened to signed so small exponents go negative instead of wrapping
    prod_next.exp  = $signed({2'b00, ops.exp_a}) + $signed({2'b00, ops.exp_b}) -
                     $signed({2'b00, `FPM_BIAS});
    prod_next.sig  = ops.sig_a * ops.sig_b;
  end

  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      prod        <= prod_next;
      special_out <= special_in;
    end
  end

endmodule

//--- fpm_classify.sv
`timescale 1ns/1ns
`include "fpm_macros.svh"

module fpm_classify (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  fpm_pkg::fp32_t       op_a,
  input  fpm_pkg::fp32_t       op_b,
  output logic                 out_valid,
  input  logic                 out_ready,
  output fpm_pkg::fpm_ops_t    ops,
  output fpm_pkg::fpm_special_t special
);

  fpm_pkg::fp_class_t    class_a;
  fpm_pkg::fp_class_t    class_b;
  fpm_pkg::fpm_special_t special_next;
  logic                  sign_x;

  // denormals count as zero
  function automatic fpm_pkg::fp_class_t op_class(input fpm_pkg::fp32_t op);
    if (op.exp == '0) begin
      return fpm_pkg::class_zero;
    end else if (op.exp == `FPM_EXP_MAX) begin
      return (op.frac == '0) ? fpm_pkg::class_inf : fpm_pkg::class_nan;
    end
    return fpm_pkg::class_normal;
  endfunction

  assign class_a = op_class(op_a);
  assign class_b = op_class(op_b);
  assign sign_x  = op_a.sign ^ op_b.sign;

  // priority: nan, inf*0, inf, zero
  always_comb begin
    special_next = '0;
    if (class_a == fpm_pkg::class_nan || class_b == fpm_pkg::class_nan) begin
      special_next.override      = 1'b1;
      special_next.result.exp    = `FPM_EXP_MAX;
      special_next.result.frac   = `FPM_QNAN_FRAC;
      special_next.flags.invalid = 1'b1;
    end else if ((class_a == fpm_pkg::class_inf && class_b == fpm_pkg::class_zero) ||
                 (class_b == fpm_pkg::class_inf && class_a == fpm_pkg::class_zero)) begin
      special_next.override      = 1'b1;
      special_next.result.sign   = 1'b1;
      special_next.result.exp    = `FPM_EXP_MAX;
      special_next.result.frac   = `FPM_QNAN_FRAC;
      special_next.flags.invalid = 1'b1;
    end else if (class_a == fpm_pkg::class_inf || class_b == fpm_pkg::class_inf) begin
      special_next.override    = 1'b1;
      special_next.result.sign = sign_x;
      special_next.result.exp  = `FPM_EXP_MAX;
    end else if (class_a == fpm_pkg::class_zero || class_b == fpm_pkg::class_zero) begin
      special_next.override    = 1'b1;
      special_next.result.sign = sign_x;
    end
  end

  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      ops.sign_a <= op_a.sign;
      ops.sign_b <= op_b.sign;
      ops.exp_a  <= op_a.exp;
      ops.exp_b  <= op_b.exp;
      ops.sig_a  <= {1'b1, op_a.frac};
      ops.sig_b  <= {1'b1, op_b.frac};
      special    <= special_next;
    end
  end

endmodule

//--- fpm_pkg.sv
`include "fpm_macros.svh"

package fpm_pkg;

  typedef struct packed {
    logic                   sign;
    logic [`FPM_EXP_W-1:0]  exp;
    logic [`FPM_MANT_W-1:0] frac;
  } fp32_t;

  typedef enum logic [1:0] {
    class_zero,
    class_normal,
    class_inf,
    class_nan
  } fp_class_t;

  typedef struct packed {
    logic invalid;
    logic overflow;
    logic underflow;
    logic inexact;
  } fpm_flags_t;

  // special-case decision made in stage 1, applied in stage 4
  typedef struct packed {
    logic       override;
    fp32_t      result;
    fpm_flags_t flags;
  } fpm_special_t;

  // significands carry the hidden one
  typedef struct packed {
    logic                  sign_a;
    logic                  sign_b;
    logic [`FPM_EXP_W-1:0] exp_a;
    logic [`FPM_EXP_W-1:0] exp_b;
    logic [`FPM_MANT_W:0]  sig_a;
    logic [`FPM_MANT_W:0]  sig_b;
  } fpm_ops_t;

  // exp is the unbiased-sum-plus-bias, two bits wider and signed
  typedef struct packed {
    logic                         sign;
    logic signed [`FPM_EXP_W+1:0] exp;
    logic [`FPM_PROD_W-1:0]       sig;
  } fpm_prod_t;

endpackage

//--- fpm_macros.svh
`ifndef FPM_MACROS_SVH
`define FPM_MACROS_SVH

// binary32 field widths
`define FPM_EXP_W 8
`define FPM_MANT_W 23

// full 24x24 significand product
`define FPM_PROD_W 48

// exponent bias and the all-ones exponent of inf and nan
`define FPM_BIAS 8'd127
`define FPM_EXP_MAX 8'd255

// canonical quiet nan fraction, top fraction bit only
`define FPM_QNAN_FRAC 23'h400000

`endif
